// File: verilog.f
common/rv_isa_pkg.sv
common/rv_alu_pkg.sv
rtl/main_control.sv
rtl/imm_gen.sv
rtl/alu_controller.sv
alu/alu.sv
rtl/execute_stage.sv
rtl/rv_execute_top.sv
test/tb_rv_execute.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
    --top-module tb_rv_execute -Mdir obj_dir -o tb_rv_execute
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/tb_rv_execute)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^No errors$"; then
    exit 0
else
    exit 1
fi

// File: test/tb_rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_execute;

    import rv_isa_pkg::*;

    // The tests need about 120 cycles
    localparam int MAX_CYCLES = 400;

    // {funct7 bit 5, funct3} of each register and immediate op
    localparam logic [3:0] R_OPS [10] = '{4'b0000, 4'b1000, 4'b0111, 4'b0110, 4'b0100,
                                          4'b0010, 4'b0011, 4'b0001, 4'b0101, 4'b1101};
    localparam logic [3:0] I_OPS [9]  = '{4'b0000, 4'b0010, 4'b0011, 4'b0100, 4'b0110,
                                          4'b0111, 4'b0001, 4'b0101, 4'b1101};
    localparam logic [2:0] BR_F3 [6]  = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    // Equal, less, signed less but unsigned greater, and the mirror cases
    localparam logic [31:0] BR_A [5] = '{32'd5, 32'd3, 32'hffff_fff0, 32'd9, 32'd4};
    localparam logic [31:0] BR_B [5] = '{32'd5, 32'd9, 32'd4, 32'd3, 32'hffff_fff0};

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        out_valid;
    logic [31:0] result;
    logic        reg_write_out;
    logic        taken;
    logic [31:0] next_pc;
    logic        illegal_out;

    logic [31:0] exp_result;
    logic        exp_rw;
    logic        exp_taken;
    logic [31:0] exp_next_pc;
    logic        exp_illegal;
    logic        exp_has_result;
    int          cycles = 0;

    rv_execute_top #(
        .XLEN (32)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .instr         (instr),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .out_valid     (out_valid),
        .result        (result),
        .reg_write_out (reg_write_out),
        .taken         (taken),
        .next_pc       (next_pc),
        .illegal_out   (illegal_out)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Errors found");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] enc_r(logic alt, logic [2:0] f3);
        enc_r = {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd3, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
        enc_i = {imm, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm);
        enc_s = {imm[11:5], 5'd2, 5'd1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [2:0] f3);
        enc_b = {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off);
        enc_j = {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
    endfunction

    // ISA result of register and immediate arithmetic
    function automatic logic [31:0] model_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                             logic [31:0] b);
        case (f3)
            F3_ADD:  model_op = alt ? a - b : a + b;
            F3_SLL:  model_op = a << b[4:0];
            F3_SLT:  model_op = {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: model_op = {31'b0, a < b};
            F3_XOR:  model_op = a ^ b;
            F3_SR:   model_op = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:   model_op = a | b;
            default: model_op = a & b;
        endcase
    endfunction

    function automatic logic branch_cond(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            F3_BEQ:  branch_cond = (a == b);
            F3_BNE:  branch_cond = (a != b);
            F3_BLT:  branch_cond = ($signed(a) < $signed(b));
            F3_BGE:  branch_cond = ($signed(a) >= $signed(b));
            F3_BLTU: branch_cond = (a < b);
            default: branch_cond = (a >= b);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, expected);
            $display("Errors found");
            $fatal(1, "check of %s failed", name);
        end
    endtask

    task automatic set_expect(input logic [31:0] res, input logic rw, input logic tk,
                              input logic [31:0] npc, input logic ill, input logic has_res);
        exp_result     = res;
        exp_rw         = rw;
        exp_taken      = tk;
        exp_next_pc    = npc;
        exp_illegal    = ill;
        exp_has_result = has_res;
    endtask

    task automatic check_idle_outputs();
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("reg_write_out", 32'(reg_write_out), 32'd0);
        check_value("taken", 32'(taken), 32'd0);
        check_value("illegal_out", 32'(illegal_out), 32'd0);
    endtask

    // Called 1 ns after an edge, returns 1 ns after the next one
    task automatic execute(input logic [31:0] ins, input logic [31:0] pc_v,
                           input logic [31:0] a, input logic [31:0] b);
        in_valid = 1'b1;
        instr    = ins;
        pc       = pc_v;
        rs1_data = a;
        rs2_data = b;
        @(posedge clk);
        #0.5;
        check_value("out_valid", 32'(out_valid), 32'd1);
        if (exp_has_result) begin
            check_value("result", result, exp_result);
        end
        check_value("reg_write_out", 32'(reg_write_out), 32'(exp_rw));
        check_value("taken", 32'(taken), 32'(exp_taken));
        check_value("next_pc", next_pc, exp_next_pc);
        check_value("illegal_out", 32'(illegal_out), 32'(exp_illegal));
        #0.5;
    endtask

    task automatic idle();
        in_valid = 1'b0;
        @(posedge clk);
        #0.5;
        check_idle_outputs();
        #0.5;
    endtask

    task automatic test_reset();
        // Valid jumps and an illegal opcode offered while reset holds the outputs low
        for (int i = 0; i < 3; i++) begin
            in_valid = 1'b1;
            pc       = 32'h80;
            if (i == 1) begin
                instr = {25'h0, 7'b0001011};
            end else begin
                instr = enc_j(21'h40);
            end
            @(posedge clk);
            #0.5;
            check_idle_outputs();
            #0.5;
        end
        reset = 1'b0;
        idle();
    endtask

    task automatic test_arith();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        logic [11:0] imm;
        for (int rep = 0; rep < 3; rep++) begin
            for (int i = 0; i < 10; i++) begin
                a = $urandom;
                b = $urandom;
                // Top bit set and a nonzero amount tell SRA from SRL
                if (R_OPS[i][2:0] == F3_SR) begin
                    a[31] = 1'b1;
                    b[0]  = 1'b1;
                end
                set_expect(model_op(R_OPS[i][2:0], R_OPS[i][3], a, b), 1'b1, 1'b0,
                           32'h100 + 32'd4, 1'b0, 1'b1);
                execute(enc_r(R_OPS[i][3], R_OPS[i][2:0]), 32'h100, a, b);
            end
            for (int i = 0; i < 9; i++) begin
                a = $urandom;
                rnd = $urandom;
                if (I_OPS[i][1:0] == 2'b01) begin
                    imm   = {1'b0, I_OPS[i][3], 5'b0, rnd[4:1], 1'b1};
                    a[31] = 1'b1;
                end else begin
                    imm = rnd[11:0];
                end
                set_expect(model_op(I_OPS[i][2:0], I_OPS[i][3], a, {{20{imm[11]}}, imm}),
                           1'b1, 1'b0, 32'h204, 1'b0, 1'b1);
                execute(enc_i(imm, I_OPS[i][2:0], OPC_OP_IMM), 32'h200, a, 32'd0);
            end
        end
    endtask

    task automatic test_upper_mem();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        logic [31:0] pc_v;
        for (int rep = 0; rep < 3; rep++) begin
            a = $urandom;
            b = $urandom;
            rnd = $urandom;
            pc_v = {b[31:2], 2'b00};
            set_expect({rnd[31:12], 12'b0}, 1'b1, 1'b0, pc_v + 32'd4, 1'b0, 1'b1);
            execute({rnd[31:12], 5'd3, OPC_LUI}, pc_v, a, b);
            set_expect(pc_v + {rnd[31:12], 12'b0}, 1'b1, 1'b0, pc_v + 32'd4, 1'b0, 1'b1);
            execute({rnd[31:12], 5'd3, OPC_AUIPC}, pc_v, a, b);
            set_expect(a + {{20{rnd[11]}}, rnd[11:0]}, 1'b1, 1'b0, pc_v + 32'd4, 1'b0, 1'b1);
            execute(enc_i(rnd[11:0], 3'b010, OPC_LOAD), pc_v, a, b);
            set_expect(a + {{20{rnd[11]}}, rnd[11:0]}, 1'b0, 1'b0, pc_v + 32'd4, 1'b0, 1'b1);
            execute(enc_s(rnd[11:0]), pc_v, a, b);
        end
    endtask

    task automatic test_branches();
        logic [31:0] rnd;
        logic [12:0] off;
        logic        tk;
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 5; p++) begin
                rnd = $urandom;
                off = {rnd[11:0], 1'b0};
                tk  = branch_cond(BR_F3[k], BR_A[p], BR_B[p]);
                set_expect(32'd0, 1'b0, tk, tk ? 32'h3000 + {{19{off[12]}}, off} : 32'h3004,
                           1'b0, 1'b0);
                execute(enc_b(off, BR_F3[k]), 32'h3000, BR_A[p], BR_B[p]);
            end
        end
    endtask

    task automatic test_jumps();
        logic [31:0] a;
        logic [31:0] rnd;
        logic [20:0] off;
        logic [11:0] imm;
        logic [31:0] sum;
        for (int rep = 0; rep < 3; rep++) begin
            rnd = $urandom;
            off = {rnd[19:0], 1'b0};
            set_expect(32'h4004, 1'b1, 1'b1, 32'h4000 + {{11{off[20]}}, off}, 1'b0, 1'b1);
            execute(enc_j(off), 32'h4000, 32'd0, 32'd0);
            // Odd rs1 plus even offset, so bit 0 has to be cleared
            a = $urandom | 32'd1;
            imm = {rnd[31:21], 1'b0};
            sum = a + {{20{imm[11]}}, imm};
            set_expect(32'h5004, 1'b1, 1'b1, {sum[31:1], 1'b0}, 1'b0, 1'b1);
            execute(enc_i(imm, 3'b000, OPC_JALR), 32'h5000, a, 32'd0);
        end
    endtask

    task automatic test_sequence();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom;
        b = $urandom;
        set_expect(a + b, 1'b1, 1'b0, 32'h6004, 1'b0, 1'b1);
        execute(enc_r(1'b0, F3_ADD), 32'h6000, a, b);
        set_expect(a - b, 1'b1, 1'b0, 32'h6008, 1'b0, 1'b1);
        execute(enc_r(1'b1, F3_ADD), 32'h6004, a, b);
        idle();
        set_expect(a ^ 32'hffff_f8f0, 1'b1, 1'b0, 32'h6010, 1'b0, 1'b1);
        execute(enc_i(12'h8f0, F3_XOR, OPC_OP_IMM), 32'h600c, a, b);
        // custom-0 opcode
        set_expect(32'd0, 1'b0, 1'b0, 32'h6014, 1'b1, 1'b0);
        execute({25'h0abcde, 7'b0001011}, 32'h6010, a, b);
        set_expect(32'd0, 1'b0, 1'b0, 32'h6018, 1'b1, 1'b0);
        execute(enc_b(13'h010, 3'b010), 32'h6014, a, a);
        idle();
        idle();
        set_expect(32'd0, 1'b0, 1'b1, 32'h6020 - 32'h20, 1'b0, 1'b0);
        execute(enc_b(13'h1fe0, F3_BEQ), 32'h6020, b, b);
        set_expect(32'h6028, 1'b1, 1'b1, 32'h6024 + 32'h100, 1'b0, 1'b1);
        execute(enc_j(21'h100), 32'h6024, a, b);
        idle();
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1_data = '0;
        rs2_data = '0;
        void'($urandom(32'h1b12));
        test_reset();
        test_arith();
        test_upper_mem();
        test_branches();
        test_jumps();
        test_sequence();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/rv_execute_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute_top #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  logic [31:0]     instr,
    input  logic [31:0]     pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic            out_valid,
    output logic [XLEN-1:0] result,
    output logic            reg_write_out,
    output logic            taken,
    output logic [31:0]     next_pc,
    output logic            illegal_out
);

    rv_alu_pkg::alu_option_t    alu_option;
    rv_alu_pkg::alu_operation_t alu_operation;
    rv_alu_pkg::src_a_sel_t     src_a_sel;
    rv_alu_pkg::src_b_sel_t     src_b_sel;
    rv_alu_pkg::imm_kind_t      imm_kind;
    rv_alu_pkg::ctrl_flow_t     ctrl_flow;
    logic                       branch_on_zero;
    logic                       reg_write;
    logic                       illegal;
    logic [31:0]                imm;
    logic [XLEN-1:0]            operand_a;
    logic [XLEN-1:0]            operand_b;
    logic [XLEN-1:0]            alu_result;

    main_control u_main_control (
        .instr          (instr),
        .alu_option     (alu_option),
        .src_a_sel      (src_a_sel),
        .src_b_sel      (src_b_sel),
        .imm_kind       (imm_kind),
        .ctrl_flow      (ctrl_flow),
        .branch_on_zero (branch_on_zero),
        .reg_write      (reg_write),
        .illegal        (illegal)
    );

    imm_gen u_imm_gen (
        .instr    (instr),
        .imm_kind (imm_kind),
        .imm      (imm)
    );

    // funct3 and bit 30 refine the option
    alu_controller u_alu_controller (
        .alu_option    (alu_option),
        .funct3        (instr[14:12]),
        .funct7_b5     (instr[30]),
        .alu_operation (alu_operation)
    );

    alu #(
        .XLEN (XLEN)
    ) u_alu (
        .operation (alu_operation),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (alu_result)
    );

    execute_stage #(
        .XLEN (XLEN)
    ) u_execute_stage (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .imm            (imm),
        .src_a_sel      (src_a_sel),
        .src_b_sel      (src_b_sel),
        .ctrl_flow      (ctrl_flow),
        .branch_on_zero (branch_on_zero),
        .reg_write      (reg_write),
        .illegal        (illegal),
        .alu_result     (alu_result),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .out_valid      (out_valid),
        .result         (result),
        .reg_write_out  (reg_write_out),
        .taken          (taken),
        .next_pc        (next_pc),
        .illegal_out    (illegal_out)
    );

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
    parameter int XLEN = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [XLEN-1:0]        pc,
    input  logic [XLEN-1:0]        rs1_data,
    input  logic [XLEN-1:0]        rs2_data,
    input  logic [XLEN-1:0]        imm,
    input  rv_alu_pkg::src_a_sel_t src_a_sel,
    input  rv_alu_pkg::src_b_sel_t src_b_sel,
    input  rv_alu_pkg::ctrl_flow_t ctrl_flow,
    input  logic                   branch_on_zero,
    input  logic                   reg_write,
    input  logic                   illegal,
    input  logic [XLEN-1:0]        alu_result,
    output logic [XLEN-1:0]        operand_a,
    output logic [XLEN-1:0]        operand_b,
    output logic                   out_valid,
    output logic [XLEN-1:0]        result,
    output logic                   reg_write_out,
    output logic                   taken,
    output logic [XLEN-1:0]        next_pc,
    output logic                   illegal_out
);

    import rv_alu_pkg::*;

    logic [XLEN-1:0] target_base;
    logic [XLEN-1:0] target_sum;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] seq_pc;
    logic            taken_d;

    always_comb begin
        case (src_a_sel)
            SRC_A_PC:   operand_a = pc;
            SRC_A_ZERO: operand_a = '0;
            default:    operand_a = rs1_data;
        endcase
    end

    always_comb begin
        case (src_b_sel)
            SRC_B_IMM:  operand_b = imm;
            SRC_B_FOUR: operand_b = XLEN'(4);
            default:    operand_b = rs2_data;
        endcase
    end

    always_comb begin
        case (ctrl_flow)
            FLOW_BRANCH: taken_d = branch_on_zero ? (alu_result == '0) : (alu_result != '0);
            FLOW_JAL:    taken_d = 1'b1;
            FLOW_JALR:   taken_d = 1'b1;
            default:     taken_d = 1'b0;
        endcase
    end

    // Targets get their own adder since the ALU holds the compare or link value
    assign target_base = (ctrl_flow == FLOW_JALR) ? rs1_data : pc;
    assign target_sum  = target_base + imm;
    assign target      = (ctrl_flow == FLOW_JALR) ? {target_sum[XLEN-1:1], 1'b0} : target_sum;
    assign seq_pc      = pc + XLEN'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid     <= 1'b0;
            reg_write_out <= 1'b0;
            taken         <= 1'b0;
            illegal_out   <= 1'b0;
        end else begin
            out_valid     <= in_valid;
            reg_write_out <= in_valid & reg_write & ~illegal;
            taken         <= in_valid & taken_d & ~illegal;
            illegal_out   <= in_valid & illegal;
        end
    end

    always_ff @(posedge clk) begin
        result  <= alu_result;
        next_pc <= taken_d ? target : seq_pc;
    end

endmodule

`default_nettype wire

// File: alu/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu #(
    parameter int XLEN = 32
) (
    input  rv_alu_pkg::alu_operation_t operation,
    input  logic [XLEN-1:0]            operand_a,
    input  logic [XLEN-1:0]            operand_b,
    output logic [XLEN-1:0]            result
);

    import rv_alu_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;
    logic           flag;

    assign shamt = operand_b[SHW-1:0];

    always_comb begin
        flag = 1'b0;
        case (operation)
            U_LOW_EQ:  flag = (operand_a <= operand_b);
            S_LOW_EQ:  flag = ($signed(operand_a) <= $signed(operand_b));
            U_HIGH_EQ: flag = (operand_a >= operand_b);
            S_HIGH_EQ: flag = ($signed(operand_a) >= $signed(operand_b));
            U_LOWER:   flag = (operand_a < operand_b);
            S_LOWER:   flag = ($signed(operand_a) < $signed(operand_b));
            U_HIGHER:  flag = (operand_a > operand_b);
            S_HIGHER:  flag = ($signed(operand_a) > $signed(operand_b));
            default:   flag = 1'b0;
        endcase
    end

    always_comb begin
        case (operation)
            ADD:               result = operand_a + operand_b;
            SUB:               result = operand_a - operand_b;
            AND:               result = operand_a & operand_b;
            OR:                result = operand_a | operand_b;
            XOR:               result = operand_a ^ operand_b;
            SHIFT_LEFT:        result = operand_a << shamt;
            SHIFT_RIGHT_LOGIC: result = operand_a >> shamt;
            SHIFT_RIGHT_ARIT:  result = $unsigned($signed(operand_a) >>> shamt);
            // Compares give 0 or 1
            default:           result = {{(XLEN-1){1'b0}}, flag};
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/alu_controller.sv
`timescale 1ns/100ps
`default_nettype none

module alu_controller (
    input  rv_alu_pkg::alu_option_t    alu_option,
    input  logic [2:0]                 funct3,
    input  logic                       funct7_b5,
    output rv_alu_pkg::alu_operation_t alu_operation
);

    import rv_isa_pkg::*;
    import rv_alu_pkg::*;

    always_comb begin
        case (alu_option)
            OPT_OP_IMM: begin
                case (funct3)
                    F3_ADD:  alu_operation = ADD;
                    F3_SLL:  alu_operation = SHIFT_LEFT;
                    F3_SLT:  alu_operation = S_LOWER;
                    F3_SLTU: alu_operation = U_LOWER;
                    F3_XOR:  alu_operation = XOR;
                    F3_OR:   alu_operation = OR;
                    F3_AND:  alu_operation = AND;
                    // SRAI when bit 30 is set, else SRLI
                    F3_SR: begin
                        if (funct7_b5) begin
                            alu_operation = SHIFT_RIGHT_ARIT;
                        end else begin
                            alu_operation = SHIFT_RIGHT_LOGIC;
                        end
                    end
                    default: alu_operation = ADD;
                endcase
            end

            OPT_OP: begin
                if (!funct7_b5) begin
                    case (funct3)
                        F3_ADD:  alu_operation = ADD;
                        F3_SLL:  alu_operation = SHIFT_LEFT;
                        F3_SLT:  alu_operation = S_LOWER;
                        F3_SLTU: alu_operation = U_LOWER;
                        F3_XOR:  alu_operation = XOR;
                        F3_SR:   alu_operation = SHIFT_RIGHT_LOGIC;
                        F3_OR:   alu_operation = OR;
                        F3_AND:  alu_operation = AND;
                        default: alu_operation = ADD;
                    endcase
                end else begin
                    case (funct3)
                        F3_ADD:  alu_operation = SUB;
                        F3_SR:   alu_operation = SHIFT_RIGHT_ARIT;
                        default: alu_operation = ADD;
                    endcase
                end
            end

            OPT_BRANCH: begin
                case (funct3)
                    // Zero result means equal
                    F3_BEQ:  alu_operation = SUB;
                    // Nonzero result means not equal
                    F3_BNE:  alu_operation = XOR;
                    F3_BLT:  alu_operation = S_LOWER;
                    F3_BGE:  alu_operation = S_HIGH_EQ;
                    F3_BLTU: alu_operation = U_LOWER;
                    F3_BGEU: alu_operation = U_HIGH_EQ;
                    default: alu_operation = ADD;
                endcase
            end

            // Loads, stores, upper immediates and the link value of jumps
            default: alu_operation = ADD;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
    input  logic [rv_isa_pkg::ILEN-1:0] instr,
    input  rv_alu_pkg::imm_kind_t       imm_kind,
    output logic [31:0]                 imm
);

    import rv_isa_pkg::*;
    import rv_alu_pkg::*;

    logic sign;

    assign sign = instr[SIGN_BIT];

    always_comb begin
        case (imm_kind)
            IMM_I: imm = {{20{sign}}, instr[31:20]};
            IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offsets are in half words
            IMM_B: imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U: imm = {instr[31:12], 12'b0};
            IMM_J: imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/main_control.sv
`timescale 1ns/100ps
`default_nettype none

module main_control (
    input  logic [rv_isa_pkg::ILEN-1:0] instr,
    output rv_alu_pkg::alu_option_t     alu_option,
    output rv_alu_pkg::src_a_sel_t      src_a_sel,
    output rv_alu_pkg::src_b_sel_t      src_b_sel,
    output rv_alu_pkg::imm_kind_t       imm_kind,
    output rv_alu_pkg::ctrl_flow_t      ctrl_flow,
    output logic                        branch_on_zero,
    output logic                        reg_write,
    output logic                        illegal
);

    import rv_isa_pkg::*;
    import rv_alu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        alu_option     = OPT_LOAD;
        src_a_sel      = SRC_A_RS1;
        src_b_sel      = SRC_B_IMM;
        imm_kind       = IMM_I;
        ctrl_flow      = FLOW_NONE;
        branch_on_zero = 1'b0;
        reg_write      = 1'b0;
        illegal        = 1'b0;

        case (opcode)
            OPC_LOAD: begin
                reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_option = OPT_OP_IMM;
                reg_write  = 1'b1;
            end
            OPC_AUIPC: begin
                alu_option = OPT_AUIPC;
                src_a_sel  = SRC_A_PC;
                imm_kind   = IMM_U;
                reg_write  = 1'b1;
            end
            OPC_STORE: begin
                alu_option = OPT_STORE;
                imm_kind   = IMM_S;
            end
            OPC_OP: begin
                alu_option = OPT_OP;
                src_b_sel  = SRC_B_RS2;
                reg_write  = 1'b1;
            end
            OPC_LUI: begin
                alu_option = OPT_LUI;
                src_a_sel  = SRC_A_ZERO;
                imm_kind   = IMM_U;
                reg_write  = 1'b1;
            end
            OPC_BRANCH: begin
                alu_option = OPT_BRANCH;
                src_b_sel  = SRC_B_RS2;
                imm_kind   = IMM_B;
                case (funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                        ctrl_flow = FLOW_BRANCH;
                    end
                    // 010 and 011 are not branches
                    default: illegal = 1'b1;
                endcase
                // Only BEQ goes through SUB
                branch_on_zero = (funct3 == F3_BEQ);
            end
            OPC_JAL: begin
                alu_option = OPT_JUMP;
                src_a_sel  = SRC_A_PC;
                src_b_sel  = SRC_B_FOUR;
                imm_kind   = IMM_J;
                ctrl_flow  = FLOW_JAL;
                reg_write  = 1'b1;
            end
            OPC_JALR: begin
                alu_option = OPT_JUMP;
                src_a_sel  = SRC_A_PC;
                src_b_sel  = SRC_B_FOUR;
                ctrl_flow  = FLOW_JALR;
                reg_write  = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: common/rv_alu_pkg.sv
`default_nettype none

package rv_alu_pkg;

    // Coarse class from main control
    typedef enum logic [3:0] {
        OPT_LOAD   = 4'b0000,
        OPT_OP_IMM = 4'b0010,
        OPT_AUIPC  = 4'b0011,
        OPT_STORE  = 4'b0100,
        OPT_OP     = 4'b0110,
        OPT_LUI    = 4'b0111,
        OPT_BRANCH = 4'b1100,
        OPT_JUMP   = 4'b1101
    } alu_option_t;

    typedef enum logic [3:0] {
        ADD               = 4'b0000,
        SUB               = 4'b0001,
        AND               = 4'b0010,
        OR                = 4'b0011,
        XOR               = 4'b0100,
        U_LOW_EQ          = 4'b0101,
        S_LOW_EQ          = 4'b0110,
        U_HIGH_EQ         = 4'b0111,
        S_HIGH_EQ         = 4'b1000,
        U_LOWER           = 4'b1001,
        S_LOWER           = 4'b1010,
        U_HIGHER          = 4'b1011,
        S_HIGHER          = 4'b1100,
        SHIFT_LEFT        = 4'b1101,
        SHIFT_RIGHT_LOGIC = 4'b1110,
        SHIFT_RIGHT_ARIT  = 4'b1111
    } alu_operation_t;

    typedef enum logic [1:0] {
        SRC_A_RS1,
        SRC_A_PC,
        SRC_A_ZERO
    } src_a_sel_t;

    typedef enum logic [1:0] {
        SRC_B_RS2,
        SRC_B_IMM,
        SRC_B_FOUR
    } src_b_sel_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_kind_t;

    typedef enum logic [1:0] {
        FLOW_NONE,
        FLOW_BRANCH,
        FLOW_JAL,
        FLOW_JALR
    } ctrl_flow_t;

endpackage

`default_nettype wire

// File: common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Instruction word layout
    localparam int unsigned ILEN     = 32;
    localparam int unsigned SIGN_BIT = 31;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Register and immediate arithmetic
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

`default_nettype wire
